//--- compile.f
logic/fm_pkg.sv
logic/slot_registers.sv
logic/slot_sequencer.sv
logic/phase_unit.sv
logic/envelope_unit.sv
logic/wave_unit.sv
logic/fm_operator.sv
logic/fm_voice_top.sv
test/fm_voice_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and scans the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module fm_voice_tb -o fm_voice_sim
./obj_dir/fm_voice_sim | tee sim.log
if grep -q "Test failures found" sim.log; then
    echo "simulation reported errors"
    exit 1
fi
echo "simulation finished without errors"

//--- test/fm_voice_tb.sv
// testbench for the fm operator bank; applies a table of writes and sweeps, checks against a model
module fm_voice_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import fm_pkg::*;

    localparam logic [1:0] ROW_WRITE = 2'd0;
    localparam logic [1:0] ROW_SWEEP = 2'd1;
    localparam logic [1:0] ROW_IDLE  = 2'd2;  // data holds the idle cycle count
    localparam logic [1:0] ROW_END   = 2'd3;  // closes a test

    typedef struct packed {
        logic [1:0] kind;
        logic [3:0] addr;
        logic [7:0] data;
    } row_t;

    logic               clk = 1'b0;
    logic               rst;
    logic               wr_en;
    logic [3:0]         wr_addr;
    logic [7:0]         wr_data;
    logic               sample_en;
    logic               out_valid;
    logic [1:0]         out_slot;
    logic signed [12:0] out_sample;

    row_t        rows [$];
    string       test_name [6] = '{"reset", "attack", "release", "feedback", "pair", "restart"};
    int          mult_x2 [16] = '{1, 2, 4, 6, 8, 10, 12, 14, 16, 18, 20, 20, 24, 24, 30, 30};
    logic [7:0]  shadow [16];  // host copy of the registers
    logic [19:0] m_acc [4];
    int          m_att [4];
    env_state_t  m_state [4];
    logic        m_prev [4];
    int          m_hist0 [2];  // newest even output per pair
    int          m_hist1 [2];
    logic [12:0] exp_sample [4];
    int          errors = 0;
    int          test_errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;
    int          limit = 0;
    logic        collecting = 1'b0;  // a sweep is expecting outputs

    fm_voice_top uut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    always @(negedge clk) begin  // out_valid outside a sweep
        if (!rst && !collecting && out_valid) begin
            $display("unexpected out_valid for slot %0d with no sweep running", out_slot);
            errors++;
            test_errors++;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, expected);
            errors++;
            test_errors++;
        end
    endtask

    // one sweep of the model, slots in order
    task automatic predict_sweep();
        logic [9:0] fnum;
        logic [9:0] idx;
        logic [7:0] addr;
        logic       kon;
        logic       con;
        int         blk, mul, ar, rr, fb, md, inc, mag, val;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            fnum = {shadow[s*4+1][2:1], shadow[s*4]};
            kon  = shadow[s*4+1][0];
            blk  = shadow[s*4+1][5:3];
            mul  = shadow[s*4+2][3:0];
            ar   = shadow[s*4+3][3:0];
            rr   = shadow[s*4+3][7:4];
            fb   = shadow[(s/2)*8+2][6:4];  // pair fields from the even slot
            con  = shadow[(s/2)*8+2][7];
            if (kon && !m_prev[s]) begin
                m_att[s]   = 511;
                m_state[s] = ENV_ATTACK;
                m_acc[s]   = '0;  // phase restart
            end else if (!kon && m_prev[s]) begin
                m_state[s] = ENV_RELEASE;
            end
            m_prev[s] = kon;
            case (m_state[s])
                ENV_ATTACK: begin
                    m_att[s] = (ar * 8 >= m_att[s]) ? 0 : m_att[s] - ar * 8;
                    if (m_att[s] == 0) m_state[s] = ENV_SUSTAIN;
                end
                ENV_RELEASE: begin
                    m_att[s] = (m_att[s] + rr * 8 >= 511) ? 511 : m_att[s] + rr * 8;
                    if (m_att[s] == 511) m_state[s] = ENV_OFF;
                end
                ENV_OFF: m_att[s] = 511;
                default: ;  // sustain holds
            endcase
            if (s % 2 == 0) begin
                md = (fb == 0) ? 0 : ((m_hist0[s/2] + m_hist1[s/2]) <<< fb) >>> 9;
            end else begin
                md = con ? 0 : m_hist0[s/2] >>> 2;  // partner output this sweep
            end
            idx      = m_acc[s][19:10] + md[9:0];
            inc      = ((int'(fnum) * mult_x2[mul]) << blk) >> 1;
            m_acc[s] = m_acc[s] + inc[19:0];
            addr     = idx[8] ? 8'd255 - idx[7:0] : idx[7:0];
            mag      = SINE_QUARTER[addr];
            val      = (mag * (511 - m_att[s])) >> 9;
            if (idx[9]) val = -val;
            exp_sample[s] = val[12:0];
            if (s % 2 == 0) begin
                m_hist1[s/2] = m_hist0[s/2];
                m_hist0[s/2] = val;
            end
        end
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [7:0] data);
        @(posedge clk);
        #2;
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        shadow[addr] = data;
        @(posedge clk);
        #2;
        wr_en = 1'b0;
    endtask

    task automatic run_sweep();
        int waited;
        int gap;
        predict_sweep();
        @(posedge clk);
        #2;
        sample_en  = 1'b1;
        collecting = 1'b1;
        @(posedge clk);
        #2;
        sample_en = 1'b0;
        for (int k = 0; k < NUM_SLOTS; k++) begin
            waited = 0;
            gap    = (k == 0) ? 1 + PIPE_LATENCY : SLOT_CYCLES;  // first output, then spacing
            do begin
                @(negedge clk);
                waited++;
            end while (!out_valid && waited < 24);
            if (!out_valid) begin
                $display("missing out_valid for slot %0d of the sweep", k);
                errors++;
                test_errors++;
                break;
            end
            if (waited != gap) begin
                $display("out_valid for slot %0d came after %0d cycles instead of %0d",
                         k, waited, gap);
                errors++;
                test_errors++;
            end
            check_value("out_slot", out_slot, k);
            check_value("out_sample", $unsigned(out_sample), exp_sample[k]);
        end
        @(posedge clk);  // past the last pulse before the monitor takes over
        #2;
        collecting = 1'b0;
    endtask

    task automatic close_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests_run, test_name[tests_run-1]);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, test_name[tests_run-1], test_errors);
        end
        test_errors = 0;
    endtask

    function automatic void add_row(input logic [1:0] kind, input logic [3:0] addr,
                                    input logic [7:0] data);
        rows.push_back('{kind, addr, data});
    endfunction

    function automatic void add_sweeps(input int n);
        for (int i = 0; i < n; i++) add_row(ROW_SWEEP, 4'd0, 8'd0);
    endfunction

    function automatic void build_table();
        add_row(ROW_IDLE, 4'd0, 8'd10);    // no sample_en, no output
        add_sweeps(2);
        add_row(ROW_END, 4'd0, 8'd0);
        add_row(ROW_WRITE, 4'd2, 8'h80);   // pair 0 additive
        add_row(ROW_WRITE, 4'd4, 8'h40);
        add_row(ROW_WRITE, 4'd6, 8'h03);   // mult 3
        add_row(ROW_WRITE, 4'd7, 8'h4f);   // ar 15, rr 4
        add_row(ROW_WRITE, 4'd5, 8'h35);   // kon, fnum 0x240, block 6
        add_sweeps(7);
        add_row(ROW_END, 4'd0, 8'd0);
        add_row(ROW_WRITE, 4'd12, 8'h90);
        add_row(ROW_WRITE, 4'd14, 8'h02);
        add_row(ROW_WRITE, 4'd15, 8'haf);  // ar 15, rr 10
        add_row(ROW_WRITE, 4'd13, 8'h39);  // kon, block 7
        add_sweeps(5);
        add_row(ROW_WRITE, 4'd13, 8'h38);  // key off, release ramp
        add_sweeps(8);
        add_row(ROW_END, 4'd0, 8'd0);
        add_row(ROW_WRITE, 4'd0, 8'h80);
        add_row(ROW_WRITE, 4'd3, 8'hff);
        add_row(ROW_WRITE, 4'd2, 8'h81);   // fb 0, con 1, mult 1
        add_row(ROW_WRITE, 4'd1, 8'h39);
        add_sweeps(5);
        add_row(ROW_WRITE, 4'd2, 8'he1);   // fb 6
        add_sweeps(6);
        add_row(ROW_END, 4'd0, 8'd0);
        add_row(ROW_WRITE, 4'd2, 8'h61);   // con 0, slot 1 phase modulated
        add_sweeps(4);
        add_row(ROW_WRITE, 4'd2, 8'he1);
        add_sweeps(2);
        add_row(ROW_END, 4'd0, 8'd0);
        add_row(ROW_WRITE, 4'd5, 8'h34);
        add_row(ROW_WRITE, 4'd1, 8'h38);
        add_sweeps(2);
        add_row(ROW_WRITE, 4'd5, 8'h35);   // second key-on
        add_row(ROW_WRITE, 4'd1, 8'h39);
        add_sweeps(3);
        add_row(ROW_END, 4'd0, 8'd0);
    endfunction

    initial begin
        rst       = 1'b1;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        sample_en = 1'b0;
        for (int i = 0; i < 16; i++) shadow[i] = '0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            m_acc[s]   = '0;
            m_att[s]   = 511;
            m_state[s] = ENV_OFF;
            m_prev[s]  = 1'b0;
        end
        for (int p = 0; p < 2; p++) begin
            m_hist0[p] = 0;
            m_hist1[p] = 0;
        end
        build_table();
        limit = rows.size() * 24 + 200;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        foreach (rows[i]) begin
            case (rows[i].kind)
                ROW_WRITE: write_reg(rows[i].addr, rows[i].data);
                ROW_SWEEP: run_sweep();
                ROW_IDLE:  repeat (rows[i].data) @(posedge clk);
                default:   close_test();
            endcase
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- logic/fm_voice_top.sv
// top level; sequencer, register block and operator pipeline
module fm_voice_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wr_en,
    input  logic [fm_pkg::REG_ADDR_WIDTH-1:0]    wr_addr,
    input  logic [fm_pkg::REG_DATA_WIDTH-1:0]    wr_data,
    input  logic                                sample_en,
    output logic                                out_valid,
    output logic [fm_pkg::SLOT_WIDTH-1:0]        out_slot,
    output logic signed [fm_pkg::OUT_WIDTH-1:0]  out_sample
);
    import fm_pkg::*;

    logic                   visit;
    logic [SLOT_WIDTH-1:0]  slot;
    logic [FNUM_WIDTH-1:0]  fnum;
    logic [BLOCK_WIDTH-1:0] block;
    logic [MULT_WIDTH-1:0]  mult;
    logic                   kon, con;
    logic [RATE_WIDTH-1:0]  ar, rr;
    logic [FB_WIDTH-1:0]    fb;

    slot_sequencer u_seq (
        .clk(clk), .rst(rst), .sample_en(sample_en), .visit(visit), .slot(slot)
    );

    slot_registers u_regs (
        .clk(clk), .rst(rst), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .slot(slot), .fnum(fnum), .block(block), .mult(mult), .kon(kon),
        .ar(ar), .rr(rr), .fb(fb), .con(con)
    );

    fm_operator u_op (
        .clk(clk), .rst(rst), .visit(visit), .slot(slot), .fnum(fnum),
        .block(block), .mult(mult), .kon(kon), .ar(ar), .rr(rr), .fb(fb),
        .con(con), .out_valid(out_valid), .out_slot(out_slot), .out_sample(out_sample)
    );

endmodule

//--- logic/fm_operator.sv
// shared operator pipeline; modulation select, feedback store and the three units
module fm_operator (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                visit,
    input  logic [fm_pkg::SLOT_WIDTH-1:0]        slot,
    input  logic [fm_pkg::FNUM_WIDTH-1:0]        fnum,
    input  logic [fm_pkg::BLOCK_WIDTH-1:0]       block,
    input  logic [fm_pkg::MULT_WIDTH-1:0]        mult,
    input  logic                                kon,
    input  logic [fm_pkg::RATE_WIDTH-1:0]        ar,
    input  logic [fm_pkg::RATE_WIDTH-1:0]        rr,
    input  logic [fm_pkg::FB_WIDTH-1:0]          fb,
    input  logic                                con,
    output logic                                out_valid,
    output logic [fm_pkg::SLOT_WIDTH-1:0]        out_slot,
    output logic signed [fm_pkg::OUT_WIDTH-1:0]  out_sample
);
    import fm_pkg::*;

    localparam int FB_SUM_WIDTH = OUT_WIDTH + 1 + 7;  // two outputs, shifted by up to 7

    logic signed [OUT_WIDTH-1:0]    hist [NUM_SLOTS/2][2];  // even slot, newest first
    logic signed [FB_SUM_WIDTH-1:0] fb_sum;
    logic signed [OUT_WIDTH-1:0]    modulation;
    logic                           key_on;
    logic [INDEX_WIDTH-1:0]         index;
    logic [ENV_WIDTH-1:0]           atten;
    logic                           valid_p1;
    logic [SLOT_WIDTH-1:0]          slot_p1, slot_p2;

    always_comb begin
        fb_sum = (FB_SUM_WIDTH'(hist[slot[1]][0]) + FB_SUM_WIDTH'(hist[slot[1]][1])) <<< fb;
        if (!slot[0]) begin
            modulation = (fb == '0) ? '0 : OUT_WIDTH'(fb_sum >>> 9);  // self feedback
        end else if (!con) begin
            modulation = hist[slot[1]][0] >>> 2;  // partner output, this sweep
        end else begin
            modulation = '0;  // additive pair
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_p1 <= 1'b0;
            for (int p = 0; p < NUM_SLOTS/2; p++) begin
                hist[p][0] <= '0;
                hist[p][1] <= '0;
            end
        end else begin
            valid_p1 <= visit;
            if (out_valid && !out_slot[0]) begin  // even outputs only
                hist[out_slot[1]][0] <= out_sample;
                hist[out_slot[1]][1] <= hist[out_slot[1]][0];
            end
        end
    end

    always_ff @(posedge clk) begin  // slot index rides along the pipe
        slot_p1  <= slot;
        slot_p2  <= slot_p1;
        out_slot <= slot_p2;
    end

    envelope_unit u_env (
        .clk(clk), .rst(rst), .visit(visit), .slot(slot), .kon(kon),
        .ar(ar), .rr(rr), .key_on(key_on), .atten(atten)
    );

    phase_unit u_phase (
        .clk(clk), .rst(rst), .visit(visit), .slot(slot), .key_on(key_on),
        .fnum(fnum), .block(block), .mult(mult), .modulation(modulation), .index(index)
    );

    wave_unit u_wave (
        .clk(clk), .rst(rst), .valid_in(valid_p1), .index(index), .atten(atten),
        .valid_out(out_valid), .sample(out_sample)
    );

    // every visit yields exactly one output three clocks later
    a_latency: assert property (@(posedge clk) disable iff (rst)
        visit |-> ##PIPE_LATENCY out_valid);
    a_no_extra: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(visit, PIPE_LATENCY));

endmodule

//--- logic/wave_unit.sv
// quarter sine lookup (P2) and envelope scaling (P3)
module wave_unit (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                valid_in,
    input  logic [fm_pkg::INDEX_WIDTH-1:0]       index,
    input  logic [fm_pkg::ENV_WIDTH-1:0]         atten,
    output logic                                valid_out,
    output logic signed [fm_pkg::OUT_WIDTH-1:0]  sample
);
    import fm_pkg::*;

    logic                              valid_p2;
    logic [SINE_WIDTH-1:0]             mag_p2;
    logic                              sign_p2;
    logic [ENV_WIDTH-1:0]              level_p2;  // 511 minus attenuation
    logic [7:0]                        addr;
    logic [SINE_WIDTH+ENV_WIDTH-1:0]   prod;
    logic [SINE_WIDTH-1:0]             scaled;

    assign addr = index[8] ? ~index[7:0] : index[7:0];  // mirrored half

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_p2  <= 1'b0;
            valid_out <= 1'b0;
        end else begin
            valid_p2  <= valid_in;
            valid_out <= valid_p2;
        end
    end

    always_ff @(posedge clk) begin
        mag_p2   <= SINE_QUARTER[addr];
        sign_p2  <= index[9];        // second half is negative
        level_p2 <= ~atten;          // 511 - atten
    end

    always_comb begin
        prod   = mag_p2 * level_p2;
        scaled = prod[SINE_WIDTH+ENV_WIDTH-1:ENV_WIDTH];  // >> 9
    end

    always_ff @(posedge clk) begin
        sample <= sign_p2 ? -$signed({1'b0, scaled}) : $signed({1'b0, scaled});
    end

endmodule

//--- logic/envelope_unit.sv
// key edges and linear attack/sustain/release attenuation per slot
module envelope_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          visit,
    input  logic [fm_pkg::SLOT_WIDTH-1:0]  slot,
    input  logic                          kon,
    input  logic [fm_pkg::RATE_WIDTH-1:0]  ar,
    input  logic [fm_pkg::RATE_WIDTH-1:0]  rr,
    output logic                          key_on,
    output logic [fm_pkg::ENV_WIDTH-1:0]   atten
);
    import fm_pkg::*;

    localparam logic [ENV_WIDTH-1:0] SILENT = '1;

    logic                 prev_key [NUM_SLOTS];
    env_state_t           state    [NUM_SLOTS];
    logic [ENV_WIDTH-1:0] att      [NUM_SLOTS];
    logic                 key_off;
    env_state_t           st_start, st_next;
    logic [ENV_WIDTH-1:0] att_start, att_next;
    logic [ENV_WIDTH:0]   step;     // rate times 8
    logic [ENV_WIDTH:0]   rel_sum;  // one bit spare for the ceiling

    assign key_on  = visit && kon && !prev_key[slot];
    assign key_off = visit && !kon && prev_key[slot];

    always_comb begin
        att_start = key_on ? SILENT : att[slot];
        st_start  = key_on ? ENV_ATTACK : (key_off ? ENV_RELEASE : state[slot]);
        st_next   = st_start;
        att_next  = att_start;
        step      = '0;
        rel_sum   = '0;
        case (st_start)
            ENV_ATTACK: begin
                step = (ENV_WIDTH+1)'(ar * ENV_STEP);
                if (step >= {1'b0, att_start}) begin  // floor at 0
                    att_next = '0;
                    st_next  = ENV_SUSTAIN;
                end else begin
                    att_next = att_start - step[ENV_WIDTH-1:0];
                end
            end
            ENV_RELEASE: begin
                step    = (ENV_WIDTH+1)'(rr * ENV_STEP);
                rel_sum = {1'b0, att_start} + step;
                if (rel_sum >= {1'b0, SILENT}) begin  // ceiling at 511
                    att_next = SILENT;
                    st_next  = ENV_OFF;
                end else begin
                    att_next = rel_sum[ENV_WIDTH-1:0];
                end
            end
            ENV_OFF:  att_next = SILENT;
            default:  att_next = att_start;  // sustain holds
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                prev_key[i] <= 1'b0;
                state[i]    <= ENV_OFF;
                att[i]      <= SILENT;
            end
            atten <= SILENT;
        end else if (visit) begin
            prev_key[slot] <= kon;
            state[slot]    <= st_next;
            att[slot]      <= att_next;
            atten          <= att_next;  // P1 level for this visit
        end
    end

    // an idle slot is always fully attenuated
    a_off_silent: assert property (@(posedge clk) disable iff (rst)
        visit |-> (state[slot] != ENV_OFF || att[slot] == SILENT));

endmodule

//--- logic/phase_unit.sv
// phase accumulators per slot and modulated wave index, registered at P1
module phase_unit (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                visit,
    input  logic [fm_pkg::SLOT_WIDTH-1:0]        slot,
    input  logic                                key_on,
    input  logic [fm_pkg::FNUM_WIDTH-1:0]        fnum,
    input  logic [fm_pkg::BLOCK_WIDTH-1:0]       block,
    input  logic [fm_pkg::MULT_WIDTH-1:0]        mult,
    input  logic signed [fm_pkg::OUT_WIDTH-1:0]  modulation,
    output logic [fm_pkg::INDEX_WIDTH-1:0]       index
);
    import fm_pkg::*;

    localparam int PROD_WIDTH = FNUM_WIDTH + 5 + 7;  // fnum*mult2 shifted by block

    logic [PHASE_WIDTH-1:0] acc [NUM_SLOTS];
    logic [PROD_WIDTH-1:0]  scaled;
    logic [PHASE_WIDTH-1:0] inc;
    logic [PHASE_WIDTH-1:0] acc_cur;  // accumulator seen by this visit

    always_comb begin
        scaled  = (PROD_WIDTH'(fnum) * PROD_WIDTH'(MULT_TABLE[mult])) << block;
        inc     = PHASE_WIDTH'(scaled >> 1);  // halve, table is 2x
        acc_cur = key_on ? '0 : acc[slot];    // restart on key-on
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                acc[i] <= '0;
            end
            index <= '0;
        end else if (visit) begin
            // index from pre-increment phase, wraps at 10 bits
            index    <= acc_cur[PHASE_WIDTH-1 -: INDEX_WIDTH]
                        + modulation[INDEX_WIDTH-1:0];
            acc[slot] <= acc_cur + inc;
        end
    end

endmodule

//--- logic/slot_sequencer.sv
// sweep sequencer; one sample_en gives four spaced slot visits
module slot_sequencer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         sample_en,
    output logic                         visit,
    output logic [fm_pkg::SLOT_WIDTH-1:0] slot
);
    import fm_pkg::*;

    logic                           busy;
    logic [$clog2(SLOT_CYCLES)-1:0] cyc;  // position inside a visit period

    assign visit = busy && (cyc == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cyc  <= '0;
            slot <= '0;
        end else if (!busy) begin
            if (sample_en) begin  // ignored while busy
                busy <= 1'b1;
                cyc  <= '0;
                slot <= '0;
            end
        end else if (visit && slot == SLOT_WIDTH'(NUM_SLOTS - 1)) begin
            busy <= 1'b0;  // free again right after the last visit
        end else begin
            cyc <= cyc + 1'b1;
            if (cyc == $bits(cyc)'(SLOT_CYCLES - 1)) begin
                slot <= slot + 1'b1;
            end
        end
    end

    // visits are spaced, never back to back
    a_visit_spaced: assert property (@(posedge clk) disable iff (rst) visit |=> !visit);

endmodule

//--- logic/slot_registers.sv
// host register file; decodes the visited slot's fields for the operator
module slot_registers (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             wr_en,
    input  logic [fm_pkg::REG_ADDR_WIDTH-1:0] wr_addr,
    input  logic [fm_pkg::REG_DATA_WIDTH-1:0] wr_data,
    input  logic [fm_pkg::SLOT_WIDTH-1:0]     slot,
    output logic [fm_pkg::FNUM_WIDTH-1:0]     fnum,
    output logic [fm_pkg::BLOCK_WIDTH-1:0]    block,
    output logic [fm_pkg::MULT_WIDTH-1:0]     mult,
    output logic                             kon,
    output logic [fm_pkg::RATE_WIDTH-1:0]     ar,
    output logic [fm_pkg::RATE_WIDTH-1:0]     rr,
    output logic [fm_pkg::FB_WIDTH-1:0]       fb,
    output logic                             con
);
    import fm_pkg::*;

    logic [REG_DATA_WIDTH-1:0] regs [2**REG_ADDR_WIDTH];
    logic [REG_DATA_WIDTH-1:0] f0, f1, f2, f3;
    logic [REG_DATA_WIDTH-1:0] pair_f2;  // field 2 of the even slot

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**REG_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;  // lands on the strobe edge
        end
    end

    always_comb begin
        f0 = regs[{slot, 2'd0}];
        f1 = regs[{slot, 2'd1}];
        f2 = regs[{slot, 2'd2}];
        f3 = regs[{slot, 2'd3}];
        pair_f2 = regs[{slot[1], 1'b0, 2'd2}];
    end

    assign fnum  = {f1[2:1], f0};  // high bits live in field 1
    assign kon   = f1[0];
    assign block = f1[5:3];
    assign mult  = f2[3:0];
    assign ar    = f3[3:0];
    assign rr    = f3[7:4];
    assign fb    = pair_f2[6:4];
    assign con   = pair_f2[7];

endmodule

//--- logic/fm_pkg.sv
// shared widths, slot timing, register fields and tables for the fm operator bank
package fm_pkg;

    localparam int NUM_SLOTS    = 4;
    localparam int SLOT_WIDTH   = 2;  // slot index
    localparam int SLOT_CYCLES  = 4;  // clocks between visits
    localparam int PIPE_LATENCY = 3;  // visit to out_valid

    localparam int REG_ADDR_WIDTH = 4;  // slot*4 + field
    localparam int REG_DATA_WIDTH = 8;

    localparam int FNUM_WIDTH  = 10;
    localparam int BLOCK_WIDTH = 3;
    localparam int MULT_WIDTH  = 4;
    localparam int FB_WIDTH    = 3;
    localparam int RATE_WIDTH  = 4;

    // twice the frequency multiple, so x0.5 stays an integer
    localparam logic [0:15][4:0] MULT_TABLE = '{
        5'd1, 5'd2, 5'd4, 5'd6, 5'd8, 5'd10, 5'd12, 5'd14,
        5'd16, 5'd18, 5'd20, 5'd20, 5'd24, 5'd24, 5'd30, 5'd30
    };

    localparam int PHASE_WIDTH = 20;  // top 10 bits index the wave
    localparam int INDEX_WIDTH = 10;
    localparam int ENV_WIDTH   = 9;   // 0 loudest, 511 silent
    localparam int ENV_STEP    = 8;   // rate multiplier
    localparam int OUT_WIDTH   = 13;  // signed sample
    localparam int SINE_WIDTH  = 12;

    typedef enum logic [1:0] {
        ENV_OFF,
        ENV_ATTACK,
        ENV_SUSTAIN,
        ENV_RELEASE
    } env_state_t;

    // quarter sine, 4095*sin((k+0.5)*pi/512), evaluated at elaboration
    function automatic logic [255:0][SINE_WIDTH-1:0] make_sine();
        logic [255:0][SINE_WIDTH-1:0] tbl;
        real x;
        real term;
        real s;
        for (int k = 0; k < 256; k++) begin
            x = (k + 0.5) * 3.14159265358979 / 512.0;
            s = x;
            term = x;
            for (int n = 1; n < 8; n++) begin  // taylor terms up to x^15
                term = -term * x * x / ((2.0 * n) * (2.0 * n + 1.0));
                s = s + term;
            end
            tbl[k] = SINE_WIDTH'($rtoi(4095.0 * s + 0.5));
        end
        return tbl;
    endfunction

    localparam logic [255:0][SINE_WIDTH-1:0] SINE_QUARTER = make_sine();

endpackage
